//--- source/lsu_pkg.sv
// load/store unit shared types
`default_nettype none

package lsu_pkg;

  localparam int XLEN   = 64;
  localparam int ADDR_W = 32;
  localparam int STRB_W = XLEN / 8;
  localparam int OFF_W  = $clog2(STRB_W);

  typedef enum logic {LOAD = 1'b0, STORE = 1'b1} mem_kind_e;

  typedef enum logic [1:0] {SZ_B = 2'd0, SZ_H = 2'd1, SZ_W = 2'd2, SZ_D = 2'd3} mem_size_e;

  typedef enum logic [1:0] {OKAY = 2'b00, SLVERR = 2'b10} resp_e;

  // operation from execute
  typedef struct packed {
    mem_kind_e         kind;
    mem_size_e         size;
    logic              is_unsigned;
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   wdata;
    logic [4:0]        rd;
  } mem_op_t;

  // issue stage output, addr is word aligned
  typedef struct packed {
    mem_kind_e         kind;
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   wdata;
    logic [STRB_W-1:0] strb;
    mem_size_e         size;
    logic              is_unsigned;
    logic [OFF_W-1:0]  offset;
    logic [4:0]        rd;
  } bus_req_t;

  // load context kept while the read is open
  typedef struct packed {
    mem_size_e        size;
    logic             is_unsigned;
    logic [OFF_W-1:0] offset;
    logic [4:0]       rd;
  } rd_ctx_t;

  typedef struct packed {
    logic            valid;
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
  } wb_t;

endpackage

`default_nettype wire

//--- source/lsu_issue.sv
// load/store issue stage
`timescale 1ns/1ps
`default_nettype none

module lsu_issue import lsu_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     op_valid_i,
  input  wire mem_op_t  op_i,
  input  wire logic     req_take_i,
  output logic          busy_o,
  output logic          req_valid_o,
  output bus_req_t      req_o
);

  logic              full_q;
  bus_req_t          req_q;
  logic [OFF_W-1:0]  offset;
  logic [OFF_W-1:0]  align_mask;
  logic [STRB_W-1:0] base_strb;

  assign offset = op_i.addr[OFF_W-1:0];

  // lane mask and low address bits that must be zero, per size
  always_comb begin
    case (op_i.size)
      SZ_B: begin
        base_strb  = STRB_W'(1);
        align_mask = OFF_W'(0);
      end
      SZ_H: begin
        base_strb  = STRB_W'(3);
        align_mask = OFF_W'(1);
      end
      SZ_W: begin
        base_strb  = STRB_W'(15);
        align_mask = OFF_W'(3);
      end
      default: begin
        base_strb  = '1;
        align_mask = OFF_W'(7);
      end
    endcase
  end

  // one-entry slot
  always_ff @(posedge clk) begin
    if (rst) begin
      full_q <= 1'b0;
    end else if (op_valid_i) begin
      full_q <= 1'b1;
    end else if (req_take_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (op_valid_i) begin
      req_q.kind        <= op_i.kind;
      req_q.addr        <= {op_i.addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
      req_q.wdata       <= op_i.wdata << {offset, 3'b000};
      req_q.strb        <= base_strb << offset;
      req_q.size        <= op_i.size;
      req_q.is_unsigned <= op_i.is_unsigned;
      req_q.offset      <= offset;
      req_q.rd          <= op_i.rd;
    end
  end

  assign busy_o      = full_q;
  assign req_valid_o = full_q;
  assign req_o       = req_q;

  // upstream waits on busy before the next strobe
  a_no_strobe_when_busy: assert property (@(posedge clk) disable iff (rst)
    op_valid_i |-> !full_q)
    else $error("op strobe while issue slot is full");

  a_natural_align: assert property (@(posedge clk) disable iff (rst)
    op_valid_i |-> (offset & align_mask) == '0)
    else $error("misaligned access at %h", op_i.addr);

endmodule

`default_nettype wire

//--- source/lsu_bus_master.sv
// load/store bus master
`timescale 1ns/1ps
`default_nettype none

module lsu_bus_master import lsu_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              req_valid_i,
  input  wire bus_req_t          req_i,
  output logic                   req_take_o,
  // write address
  output logic                   aw_valid_o,
  input  wire logic              aw_ready_i,
  output logic [ADDR_W-1:0]      aw_addr_o,
  // write data
  output logic                   w_valid_o,
  input  wire logic              w_ready_i,
  output logic [XLEN-1:0]        w_data_o,
  output logic [STRB_W-1:0]      w_strb_o,
  // write response
  input  wire logic              b_valid_i,
  output logic                   b_ready_o,
  input  wire resp_e             b_resp_i,
  // read address
  output logic                   ar_valid_o,
  input  wire logic              ar_ready_i,
  output logic [ADDR_W-1:0]      ar_addr_o,
  // read data
  input  wire logic              r_valid_i,
  output logic                   r_ready_o,
  input  wire logic [XLEN-1:0]   r_data_i,
  input  wire resp_e             r_resp_i,
  // to load alignment
  output logic                   rd_valid_o,
  output logic [XLEN-1:0]        rd_data_o,
  output rd_ctx_t                rd_ctx_o
);

  typedef enum logic [1:0] {W_IDLE, W_ADDR_DATA, W_RESP} w_state_e;
  typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA} r_state_e;

  w_state_e          w_state;
  r_state_e          r_state;
  logic              aw_valid_q;
  logic              w_valid_q;
  logic              b_ready_q;
  logic              ar_valid_q;
  logic              r_ready_q;
  logic [ADDR_W-1:0] addr_q;
  logic [XLEN-1:0]   wdata_q;
  logic [STRB_W-1:0] strb_q;
  rd_ctx_t           ctx_q;
  logic              aw_done;
  logic              w_done;

  // a new request starts only with both channels quiet
  assign req_take_o = req_valid_i && (w_state == W_IDLE) && (r_state == R_IDLE);

  assign aw_done = !aw_valid_q || aw_ready_i;
  assign w_done  = !w_valid_q || w_ready_i;

  //============================================================
  // write channel
  //============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      w_state    <= W_IDLE;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      b_ready_q  <= 1'b0;
    end else begin
      case (w_state)
        W_IDLE: begin
          if (req_take_o && req_i.kind == STORE) begin
            w_state    <= W_ADDR_DATA;
            aw_valid_q <= 1'b1;
            w_valid_q  <= 1'b1;
          end
        end
        W_ADDR_DATA: begin
          // aw and w may complete in either order
          if (aw_valid_q && aw_ready_i) begin
            aw_valid_q <= 1'b0;
          end
          if (w_valid_q && w_ready_i) begin
            w_valid_q <= 1'b0;
          end
          if (aw_done && w_done) begin
            w_state   <= W_RESP;
            b_ready_q <= 1'b1;
          end
        end
        W_RESP: begin
          if (b_valid_i) begin
            w_state   <= W_IDLE;
            b_ready_q <= 1'b0;
          end
        end
        default: w_state <= W_IDLE;
      endcase
    end
  end

  //============================================================
  // read channel
  //============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      r_state    <= R_IDLE;
      ar_valid_q <= 1'b0;
      r_ready_q  <= 1'b0;
    end else begin
      case (r_state)
        R_IDLE: begin
          if (req_take_o && req_i.kind == LOAD) begin
            r_state    <= R_ADDR;
            ar_valid_q <= 1'b1;
          end
        end
        R_ADDR: begin
          if (ar_ready_i) begin
            r_state    <= R_DATA;
            ar_valid_q <= 1'b0;
            r_ready_q  <= 1'b1;
          end
        end
        R_DATA: begin
          if (r_valid_i) begin
            r_state   <= R_IDLE;
            r_ready_q <= 1'b0;
          end
        end
        default: r_state <= R_IDLE;
      endcase
    end
  end

  // request payload, held for the whole transaction
  always_ff @(posedge clk) begin
    if (req_take_o) begin
      addr_q  <= req_i.addr;
      wdata_q <= req_i.wdata;
      strb_q  <= req_i.strb;
      ctx_q   <= '{size: req_i.size, is_unsigned: req_i.is_unsigned,
                   offset: req_i.offset, rd: req_i.rd};
    end
  end

  assign aw_valid_o = aw_valid_q;
  assign aw_addr_o  = addr_q;
  assign w_valid_o  = w_valid_q;
  assign w_data_o   = wdata_q;
  assign w_strb_o   = strb_q;
  assign b_ready_o  = b_ready_q;
  assign ar_valid_o = ar_valid_q;
  assign ar_addr_o  = addr_q;
  assign r_ready_o  = r_ready_q;

  // raw beat goes straight on, alignment registers it
  assign rd_valid_o = (r_state == R_DATA) && r_valid_i;
  assign rd_data_o  = r_data_i;
  assign rd_ctx_o   = ctx_q;

  a_one_open_txn: assert property (@(posedge clk) disable iff (rst)
    !((w_state != W_IDLE) && (r_state != R_IDLE)))
    else $error("read and write transactions open together");

  // slave never reports an error
  a_resp_okay: assert property (@(posedge clk) disable iff (rst)
    (b_valid_i && b_ready_q) || (r_valid_i && r_ready_q)
      |-> (b_valid_i ? b_resp_i == OKAY : r_resp_i == OKAY))
    else $error("non-OKAY response from memory");

endmodule

`default_nettype wire

//--- source/lsu_load_align.sv
// load data alignment and writeback
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align import lsu_pkg::*; (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            rd_valid_i,
  input  wire logic [XLEN-1:0] rd_data_i,
  input  wire rd_ctx_t         rd_ctx_i,
  output wb_t                  wb_o
);

  logic [XLEN-1:0] shifted;
  logic [XLEN-1:0] ext;
  logic            fill;
  logic            wb_valid_q;
  logic [4:0]      wb_rd_q;
  logic [XLEN-1:0] wb_data_q;

  // bring the addressed bytes down to lane 0
  assign shifted = rd_data_i >> {rd_ctx_i.offset, 3'b000};
  assign fill    = !rd_ctx_i.is_unsigned;

  always_comb begin
    case (rd_ctx_i.size)
      SZ_B:    ext = {{(XLEN-8){fill & shifted[7]}}, shifted[7:0]};
      SZ_H:    ext = {{(XLEN-16){fill & shifted[15]}}, shifted[15:0]};
      SZ_W:    ext = {{(XLEN-32){fill & shifted[31]}}, shifted[31:0]};
      default: ext = shifted;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= rd_valid_i;
    end
  end

  // x0 is written too, the register file drops it
  always_ff @(posedge clk) begin
    if (rd_valid_i) begin
      wb_rd_q   <= rd_ctx_i.rd;
      wb_data_q <= ext;
    end
  end

  assign wb_o = '{valid: wb_valid_q, rd: wb_rd_q, data: wb_data_q};

endmodule

`default_nettype wire

//--- source/mem_slave.sv
// memory slave with random channel delays
`timescale 1ns/1ps
`default_nettype none

module mem_slave import lsu_pkg::*; #(
  parameter int DEPTH_WORDS = 64
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              aw_valid_i,
  output logic                   aw_ready_o,
  input  wire logic [ADDR_W-1:0] aw_addr_i,
  input  wire logic              w_valid_i,
  output logic                   w_ready_o,
  input  wire logic [XLEN-1:0]   w_data_i,
  input  wire logic [STRB_W-1:0] w_strb_i,
  output logic                   b_valid_o,
  input  wire logic              b_ready_i,
  output resp_e                  b_resp_o,
  input  wire logic              ar_valid_i,
  output logic                   ar_ready_o,
  input  wire logic [ADDR_W-1:0] ar_addr_i,
  output logic                   r_valid_o,
  input  wire logic              r_ready_i,
  output logic [XLEN-1:0]        r_data_o,
  output resp_e                  r_resp_o
);

  // depth is a power of two, so the low index bits give the modulo
  localparam int IDX_W = $clog2(DEPTH_WORDS);
  localparam int NCH   = 5;

  logic [XLEN-1:0]   mem [DEPTH_WORDS];
  logic [15:0]       lfsr_q;
  logic [1:0]        dly_q [NCH];
  logic [NCH-1:0]    want;
  logic [NCH-1:0]    go;
  logic              aw_got_q;
  logic              w_got_q;
  logic              b_pend_q;
  logic              r_pend_q;
  logic [IDX_W-1:0]  w_idx_q;
  logic [XLEN-1:0]   w_data_q;
  logic [STRB_W-1:0] w_strb_q;
  logic [XLEN-1:0]   r_data_q;

  // channel order: aw, w, ar, b, r
  assign want = {r_pend_q, b_pend_q, ar_valid_i, w_valid_i && !w_got_q,
                 aw_valid_i && !aw_got_q};

  always_comb begin
    for (int i = 0; i < NCH; i++) begin
      go[i] = want[i] && (dly_q[i] == 2'd0);
    end
  end

  assign aw_ready_o = go[0];
  assign w_ready_o  = go[1];
  assign ar_ready_o = go[2];
  assign b_valid_o  = go[3];
  assign r_valid_o  = go[4];
  assign r_data_o   = r_data_q;
  assign b_resp_o   = OKAY;
  assign r_resp_o   = OKAY;

  // delay counters, reloaded from the LFSR after each transfer
  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr_q <= 16'hace1;
      for (int i = 0; i < NCH; i++) begin
        dly_q[i] <= 2'd0;
      end
    end else begin
      lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      for (int i = 0; i < NCH; i++) begin
        if (go[i] && (i < 3 || (i == 3 ? b_ready_i : r_ready_i))) begin
          dly_q[i] <= lfsr_q[2*i +: 2];
        end else if (want[i] && dly_q[i] != 2'd0) begin
          dly_q[i] <= dly_q[i] - 2'd1;
        end
      end
    end
  end

  //============================================================
  // write path and read path
  //============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      aw_got_q <= 1'b0;
      w_got_q  <= 1'b0;
      b_pend_q <= 1'b0;
      r_pend_q <= 1'b0;
      for (int i = 0; i < DEPTH_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (go[0]) begin
        aw_got_q <= 1'b1;
        w_idx_q  <= aw_addr_i[OFF_W +: IDX_W];
      end
      if (go[1]) begin
        w_got_q  <= 1'b1;
        w_data_q <= w_data_i;
        w_strb_q <= w_strb_i;
      end
      // both halves in, commit the bytes and queue the response
      if (aw_got_q && w_got_q) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (w_strb_q[b]) begin
            mem[w_idx_q][8*b +: 8] <= w_data_q[8*b +: 8];
          end
        end
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
        b_pend_q <= 1'b1;
      end
      if (go[3] && b_ready_i) begin
        b_pend_q <= 1'b0;
      end
      if (go[2]) begin
        r_pend_q <= 1'b1;
        r_data_q <= mem[ar_addr_i[OFF_W +: IDX_W]];
      end
      if (go[4] && r_ready_i) begin
        r_pend_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/lsu_top.sv
// load/store unit top
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; #(
  parameter int MEM_WORDS = 64
) (
  input  wire logic    clk,
  input  wire logic    rst,
  input  wire logic    op_valid_i,
  input  wire mem_op_t op_i,
  output logic         busy_o,
  output wb_t          wb_o
);

  logic              req_valid;
  logic              req_take;
  bus_req_t          req;
  logic              aw_valid;
  logic              aw_ready;
  logic [ADDR_W-1:0] aw_addr;
  logic              w_valid;
  logic              w_ready;
  logic [XLEN-1:0]   w_data;
  logic [STRB_W-1:0] w_strb;
  logic              b_valid;
  logic              b_ready;
  resp_e             b_resp;
  logic              ar_valid;
  logic              ar_ready;
  logic [ADDR_W-1:0] ar_addr;
  logic              r_valid;
  logic              r_ready;
  logic [XLEN-1:0]   r_data;
  resp_e             r_resp;
  logic              rd_valid;
  logic [XLEN-1:0]   rd_data;
  rd_ctx_t           rd_ctx;

  lsu_issue u_issue (
    .clk         (clk),
    .rst         (rst),
    .op_valid_i  (op_valid_i),
    .op_i        (op_i),
    .req_take_i  (req_take),
    .busy_o      (busy_o),
    .req_valid_o (req_valid),
    .req_o       (req)
  );

  lsu_bus_master u_bus_master (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid),
    .req_i       (req),
    .req_take_o  (req_take),
    .aw_valid_o  (aw_valid),
    .aw_ready_i  (aw_ready),
    .aw_addr_o   (aw_addr),
    .w_valid_o   (w_valid),
    .w_ready_i   (w_ready),
    .w_data_o    (w_data),
    .w_strb_o    (w_strb),
    .b_valid_i   (b_valid),
    .b_ready_o   (b_ready),
    .b_resp_i    (b_resp),
    .ar_valid_o  (ar_valid),
    .ar_ready_i  (ar_ready),
    .ar_addr_o   (ar_addr),
    .r_valid_i   (r_valid),
    .r_ready_o   (r_ready),
    .r_data_i    (r_data),
    .r_resp_i    (r_resp),
    .rd_valid_o  (rd_valid),
    .rd_data_o   (rd_data),
    .rd_ctx_o    (rd_ctx)
  );

  lsu_load_align u_load_align (
    .clk        (clk),
    .rst        (rst),
    .rd_valid_i (rd_valid),
    .rd_data_i  (rd_data),
    .rd_ctx_i   (rd_ctx),
    .wb_o       (wb_o)
  );

  mem_slave #(
    .DEPTH_WORDS (MEM_WORDS)
  ) u_mem (
    .clk        (clk),
    .rst        (rst),
    .aw_valid_i (aw_valid),
    .aw_ready_o (aw_ready),
    .aw_addr_i  (aw_addr),
    .w_valid_i  (w_valid),
    .w_ready_o  (w_ready),
    .w_data_i   (w_data),
    .w_strb_i   (w_strb),
    .b_valid_o  (b_valid),
    .b_ready_i  (b_ready),
    .b_resp_o   (b_resp),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .ar_addr_i  (ar_addr),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready),
    .r_data_o   (r_data),
    .r_resp_o   (r_resp)
  );

endmodule

`default_nettype wire

//--- test/lsu_checker.sv
// writeback checker with reference memory
`timescale 1ns/1ps
`default_nettype none

module lsu_checker import lsu_pkg::*; #(
  parameter int MEM_WORDS = 64
) (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       op_valid_i,
  input  wire mem_op_t    op_i,
  input  wire logic       busy_i,
  input  wire wb_t        wb_i,
  input  wire logic [2:0] test_id_i,
  input  wire logic       drain_i,
  output int              data_errs_o,
  output int              rd_errs_o,
  output int              misc_errs_o,
  output int              pending_o
);

  // one expected load writeback
  typedef struct packed {
    logic [2:0]      tid;
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
  } expect_t;

  logic [XLEN-1:0] model [MEM_WORDS];
  expect_t         exp_q [$];
  expect_t         head;
  logic            op_seen;
  logic            drained;
  int              data_errs = 0;
  int              rd_errs = 0;
  int              misc_errs = 0;
  int              pending = 0;

  assign data_errs_o = data_errs;
  assign rd_errs_o   = rd_errs;
  assign misc_errs_o = misc_errs;
  assign pending_o   = pending;

  function automatic string test_label(input logic [2:0] tid);
    case (tid)
      3'd0:    return "reset_state";
      3'd1:    return "word_round_trip";
      3'd2:    return "subword_stores";
      3'd3:    return "load_extension";
      3'd4:    return "random_mix";
      default: return "unknown";
    endcase
  endfunction

  // gather the loaded bytes, then extend from the top one
  function automatic logic [XLEN-1:0] load_value(input logic [XLEN-1:0] word, input int off,
                                                 input int nbytes, input logic uns);
    logic [XLEN-1:0] val;
    val = '0;
    for (int b = 0; b < nbytes; b++) begin
      val[8*b +: 8] = word[8*(off+b) +: 8];
    end
    if (!uns && val[8*nbytes-1]) begin
      for (int b = nbytes; b < STRB_W; b++) begin
        val[8*b +: 8] = 8'hff;
      end
    end
    return val;
  endfunction

  //============================================================
  // model update and writeback comparison
  //============================================================
  always @(posedge clk) begin : watch
    int idx;
    int off;
    int nbytes;
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        model[i] = '0;
      end
      exp_q.delete();
      op_seen = 1'b0;
      drained = 1'b0;
    end else begin
      // nothing may move before the first operation
      if (!op_seen && (busy_i || wb_i.valid)) begin
        $display("busy or writeback active after reset with no operation issued");
        misc_errs++;
        op_seen = 1'b1;
      end
      if (wb_i.valid) begin
        if (exp_q.size() == 0) begin
          $display("writeback to x%0d arrived with no load outstanding", wb_i.rd);
          misc_errs++;
        end else begin
          head = exp_q.pop_front();
          if (wb_i.rd !== head.rd) begin
            $display("ERR %s: rd expected %0d actual %0d",
                     test_label(head.tid), head.rd, wb_i.rd);
            rd_errs++;
          end
          if (wb_i.data !== head.data) begin
            $display("ERR %s: data expected %h actual %h",
                     test_label(head.tid), head.data, wb_i.data);
            data_errs++;
          end
        end
      end
      // stores land in the model at issue, loads read it at issue
      if (op_valid_i) begin
        op_seen = 1'b1;
        idx     = int'(op_i.addr[ADDR_W-1:OFF_W]) % MEM_WORDS;
        off     = int'(op_i.addr[OFF_W-1:0]);
        nbytes  = 1 << op_i.size;
        if (op_i.kind == STORE) begin
          for (int b = 0; b < nbytes; b++) begin
            model[idx][8*(off+b) +: 8] = op_i.wdata[8*b +: 8];
          end
        end else begin
          exp_q.push_back('{tid: test_id_i, rd: op_i.rd,
                            data: load_value(model[idx], off, nbytes, op_i.is_unsigned)});
        end
      end
      if (drain_i && !drained) begin
        drained = 1'b1;
        if (exp_q.size() != 0) begin
          $display("%0d loads never produced a writeback", exp_q.size());
          misc_errs++;
        end
      end
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

//--- test/tb_lsu.sv
// load/store unit testbench
`timescale 1ns/1ps
`default_nettype none

module tb_lsu import lsu_pkg::*; ();

  localparam int MEM_WORDS    = 64;
  localparam int RESET_LOADS  = MEM_WORDS;
  localparam int ROUND_TRIPS  = 8;
  localparam int SUBWORD_OPS  = 26;
  localparam int EXTEND_OPS   = 29;
  localparam int RANDOM_OPS   = 2000;
  localparam int TOTAL_OPS    = RESET_LOADS + 2 * ROUND_TRIPS + SUBWORD_OPS + EXTEND_OPS
                                + RANDOM_OPS;
  localparam int LIMIT_CYCLES = 400 * TOTAL_OPS;

  logic        clk;
  logic        rst;
  logic        op_valid;
  mem_op_t     op;
  logic        busy;
  wb_t         wb;
  logic [2:0]  test_id;
  logic        drain;
  logic [31:0] rng;
  int          data_errs;
  int          rd_errs;
  int          misc_errs;
  int          pending;

  lsu_top #(
    .MEM_WORDS (MEM_WORDS)
  ) DUT (
    .clk        (clk),
    .rst        (rst),
    .op_valid_i (op_valid),
    .op_i       (op),
    .busy_o     (busy),
    .wb_o       (wb)
  );

  lsu_checker #(
    .MEM_WORDS (MEM_WORDS)
  ) u_checker (
    .clk         (clk),
    .rst         (rst),
    .op_valid_i  (op_valid),
    .op_i        (op),
    .busy_i      (busy),
    .wb_i        (wb),
    .test_id_i   (test_id),
    .drain_i     (drain),
    .data_errs_o (data_errs),
    .rd_errs_o   (rd_errs),
    .misc_errs_o (misc_errs),
    .pending_o   (pending)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  task automatic report_counts();
    $display("errors: %0d data, %0d rd, %0d other", data_errs, rd_errs, misc_errs);
  endtask

  //============================================================
  // operation driver
  //============================================================
  // entered just after a rising edge, leaves two edges after the strobe
  task automatic send_op(input mem_kind_e op_kind, input mem_size_e op_size,
                         input logic op_uns, input logic [ADDR_W-1:0] op_addr,
                         input logic [XLEN-1:0] op_data, input logic [4:0] op_rd);
    while (busy) begin
      @(posedge clk);
    end
    op <= '{kind: op_kind, size: op_size, is_unsigned: op_uns, addr: op_addr,
            wdata: op_data, rd: op_rd};
    op_valid <= 1'b1;
    @(posedge clk);
    op_valid <= 1'b0;
    @(posedge clk);
  endtask

  task automatic store_op(input mem_size_e sz, input int addr, input logic [XLEN-1:0] data);
    send_op(STORE, sz, 1'b0, addr, data, 5'd0);
  endtask

  task automatic load_op(input mem_size_e sz, input logic uns, input int addr,
                         input logic [4:0] rd);
    send_op(LOAD, sz, uns, addr, '0, rd);
  endtask

  //============================================================
  // tests
  //============================================================
  task automatic run_reset_state();
    test_id <= 3'd0;
    // idle stretch, the checker watches busy and wb here
    repeat (5) @(posedge clk);
    for (int w = 0; w < RESET_LOADS; w++) begin
      load_op(SZ_D, 1'b0, w * 8, 5'(w));
    end
  endtask

  task automatic run_round_trip();
    int              addr;
    logic [XLEN-1:0] data;
    test_id <= 3'd1;
    for (int i = 0; i < ROUND_TRIPS; i++) begin
      addr = int'(next_rand() % MEM_WORDS) * 8;
      data = {next_rand(), next_rand()};
      store_op(SZ_D, addr, data);
      load_op(SZ_D, 1'b0, addr, 5'(next_rand()));
    end
  endtask

  task automatic run_subword();
    int base;
    test_id <= 3'd2;
    base = 5 * 8;
    store_op(SZ_D, base, 64'h0123_4567_89ab_cdef);
    for (int off = 0; off < 8; off++) begin
      store_op(SZ_B, base + off, {next_rand(), next_rand()});
      load_op(SZ_D, 1'b0, base, 5'(off + 1));
    end
    base = 21 * 8;
    store_op(SZ_D, base, 64'hfedc_ba98_7654_3210);
    for (int off = 0; off < 8; off += 2) begin
      store_op(SZ_H, base + off, {next_rand(), next_rand()});
      load_op(SZ_D, 1'b0, base, 5'(off + 9));
    end
  endtask

  // every byte, half and word of this pattern has its top bit set
  task automatic run_extension();
    int base;
    test_id <= 3'd3;
    base = 9 * 8;
    store_op(SZ_D, base, 64'hf1e2_d3c4_b5a6_9788);
    for (int off = 0; off < 8; off++) begin
      load_op(SZ_B, 1'b0, base + off, 5'd1);
      load_op(SZ_B, 1'b1, base + off, 5'd2);
    end
    for (int off = 0; off < 8; off += 2) begin
      load_op(SZ_H, 1'b0, base + off, 5'd3);
      load_op(SZ_H, 1'b1, base + off, 5'd4);
    end
    for (int off = 0; off < 8; off += 4) begin
      load_op(SZ_W, 1'b0, base + off, 5'd5);
      load_op(SZ_W, 1'b1, base + off, 5'd6);
    end
  endtask

  task automatic run_random();
    logic [31:0] r;
    mem_size_e   sz;
    int          addr;
    test_id <= 3'd4;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      r    = next_rand();
      sz   = mem_size_e'(r[2:1]);
      addr = int'(next_rand() % (MEM_WORDS * 8));
      // natural alignment for the chosen size
      addr = (addr >> sz) << sz;
      if (r[0]) begin
        store_op(sz, addr, {next_rand(), next_rand()});
      end else begin
        load_op(sz, r[3], addr, r[8:4]);
      end
    end
  endtask

  initial begin
    rng      = 32'haf26;
    rst      = 1'b1;
    op_valid = 1'b0;
    op       = '0;
    test_id  = 3'd0;
    drain    = 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    run_reset_state();
    run_round_trip();
    run_subword();
    run_extension();
    run_random();
    // last loads still on the bus, bounded wait
    @(negedge clk);
    for (int n = 0; n < 400 && (busy || pending != 0); n++) begin
      @(negedge clk);
    end
    @(posedge clk);
    drain <= 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    report_counts();
    if (data_errs + rd_errs + misc_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles, the unit stopped completing operations",
             LIMIT_CYCLES);
    report_counts();
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
source/lsu_pkg.sv
source/lsu_issue.sv
source/lsu_bus_master.sv
source/lsu_load_align.sv
source/mem_slave.sv
source/lsu_top.sv
test/lsu_checker.sv
test/tb_lsu.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the load/store unit simulation with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
build=obj_dir

verilator --binary --timing --assert -f flist.f --top-module tb_lsu -Mdir "$build" -o sim_lsu
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./"$build"/sim_lsu > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" "$log"; then
  exit 1
fi
if ! grep -q ">>> PASS" "$log"; then
  echo "no pass line in $log"
  exit 1
fi
exit 0
